// ==== all.f ====
+incdir+verilog
+incdir+verification
verilog/floor_pkg.sv
verilog/car_pkg.sv
verilog/request_capture.sv
verilog/request_queue.sv
verilog/car_dispatch.sv
verilog/floor_controller.sv
verification/floor_controller_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the floor controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module floor_controller_tb \
    -f all.f -o Vfloor_controller_tb

# The result is read from the log, not from the exit status
./obj_dir/Vfloor_controller_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Testbench reported an error, see sim.log"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "Run ended without a result, see sim.log"
    exit 1
fi
echo "Run passed"

// ==== verification/floor_controller_tasks.svh ====
// Floor controller testbench tasks that drive buttons and car status, wait and run each test
`ifndef FLOOR_CONTROLLER_TASKS_SVH
`define FLOOR_CONTROLLER_TASKS_SVH

////////////////////
// Checks and waits
////////////////////

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        stop_on_error($sformatf("Fail %s: got %h, expected %h", name, actual, expected));
    end
endtask

task automatic wait_for_activate(input floor_pkg::floor_t floor);
    int cycles;
    cycles = 0;
    while (!(car_command.activate && car_command.target_floor == floor)) begin
        @(negedge clock);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            stop_on_error($sformatf("Timeout: car never commanded toward floor number %0d", floor));
        end
    end
endtask

task automatic wait_for_lamp_off(input floor_pkg::floor_t floor);
    int cycles;
    cycles = 0;
    while (call_lights[floor] || panel_lights[floor]) begin
        @(negedge clock);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            stop_on_error($sformatf("Timeout: lamps of floor number %0d stayed on", floor));
        end
    end
endtask

task automatic wait_for_dark();
    int cycles;
    cycles = 0;
    while (call_lights != '0 || panel_lights != '0) begin
        @(negedge clock);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            stop_on_error("Timeout: lamps stayed on after power went off");
        end
    end
endtask

////////////////////
// Stimulus
////////////////////

// Holds one button until its lamp lights, then lets go
task automatic press_button(input logic panel, input floor_pkg::floor_t floor);
    int cycles;
    @(negedge clock);
    panel_buttons[floor] = panel;
    call_buttons[floor]  = !panel;
    cycles = 0;
    while (!(panel ? panel_lights[floor] : call_lights[floor])) begin
        @(negedge clock);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            stop_on_error($sformatf("Timeout: lamp of floor number %0d never lit", floor));
        end
    end
    call_buttons  = '0;
    panel_buttons = '0;
endtask

// Press that must leave every lamp dark and the car idle
task automatic hold_ignored_press(input logic panel, input floor_pkg::floor_t floor);
    @(negedge clock);
    panel_buttons[floor] = panel;
    call_buttons[floor]  = !panel;
    repeat (5) begin
        @(negedge clock);
        check_value("call_lights", 32'(call_lights), 32'd0);
        check_value("panel_lights", 32'(panel_lights), 32'd0);
        check_value("car_command.activate", 32'(car_command.activate), 32'd0);
    end
    call_buttons  = '0;
    panel_buttons = '0;
endtask

task automatic observe_idle();
    repeat (6) begin
        @(negedge clock);
        check_value("car_command.activate", 32'(car_command.activate), 32'd0);
    end
endtask

// Short run, then the car stops at the given floor
task automatic move_car(input floor_pkg::floor_t floor);
    @(negedge clock);
    car_status.moving = 1'b1;
    @(negedge clock);
    car_status.current_floor = floor;
    car_status.moving        = 1'b0;
endtask

////////////////////
// Directed tests
////////////////////

task automatic test_reset_state();
    check_value("call_lights", 32'(call_lights), 32'd0);
    check_value("panel_lights", 32'(panel_lights), 32'd0);
    check_value("car_command.activate", 32'(car_command.activate), 32'd0);
    check_value("door_permit", 32'(door_permit), 32'd0);
endtask

task automatic test_single_trip();
    floor_pkg::floor_t target;
    target = floor_pkg::floor_t'(1 + $unsigned($random(seed)) % (`FLOOR_COUNT - 1));
    press_button(1'b1, target);
    check_value("panel_lights", 32'(panel_lights), 32'(1) << target);
    wait_for_activate(target);
    check_value("car_command.direction_up", 32'(car_command.direction_up), 32'd1);
    move_car(target);
    wait_for_lamp_off(target);
    check_value("car_command.activate", 32'(car_command.activate), 32'd0);
endtask

// Oldest request goes first, whatever the direction
task automatic test_arrival_order();
    move_car(4'd4);
    press_button(1'b0, 4'd7);
    press_button(1'b1, 4'd2);
    check_value("call_lights", 32'(call_lights), 32'(1) << 7);
    wait_for_activate(4'd7);
    check_value("car_command.direction_up", 32'(car_command.direction_up), 32'd1);
    move_car(4'd7);
    wait_for_lamp_off(4'd7);
    wait_for_activate(4'd2);
    check_value("car_command.direction_up", 32'(car_command.direction_up), 32'd0);
    move_car(4'd2);
    wait_for_lamp_off(4'd2);
endtask

task automatic test_blocked_presses();
    hold_ignored_press(1'b1, 4'd2);
    hold_ignored_press(1'b0, 4'd2);
    emergency = 1'b1;
    hold_ignored_press(1'b1, 4'd9);
    hold_ignored_press(1'b0, 4'd0);
    emergency = 1'b0;
    // Request accepted, then emergency arrives before the command
    press_button(1'b1, 4'd9);
    emergency = 1'b1;
    observe_idle();
    check_value("panel_lights", 32'(panel_lights), 32'(1) << 9);
    emergency = 1'b0;
    wait_for_activate(4'd9);
    move_car(4'd9);
    wait_for_lamp_off(4'd9);
endtask

task automatic test_power_loss();
    press_button(1'b1, 4'd0);
    press_button(1'b0, 4'd5);
    @(negedge clock);
    power = 1'b0;
    wait_for_dark();
    check_value("car_command.activate", 32'(car_command.activate), 32'd0);
    @(negedge clock);
    power = 1'b1;
    observe_idle();
    check_value("call_lights", 32'(call_lights), 32'd0);
    check_value("panel_lights", 32'(panel_lights), 32'd0);
endtask

// Permit order is open then close
task automatic test_door_permits();
    @(negedge clock);
    door_open_button = 1'b1;
    @(negedge clock);
    check_value("door_permit", 32'(door_permit), 32'b10);
    door_open_button  = 1'b0;
    door_close_button = 1'b1;
    @(negedge clock);
    check_value("door_permit", 32'(door_permit), 32'b01);
    car_status.moving = 1'b1;
    @(negedge clock);
    check_value("door_permit", 32'(door_permit), 32'b00);
    car_status.moving = 1'b0;
    power             = 1'b0;
    door_open_button  = 1'b1;
    @(negedge clock);
    check_value("door_permit", 32'(door_permit), 32'b00);
    // Open button still held as power returns
    power             = 1'b1;
    door_close_button = 1'b0;
    @(negedge clock);
    check_value("door_permit", 32'(door_permit), 32'b10);
    door_open_button  = 1'b0;
endtask

`endif

// ==== verification/floor_controller_tb.sv ====
// Floor controller testbench with clock, reset, DUT instance and the directed test sequence
`timescale 1ns/1ps
`default_nettype none

`include "elevator_consts.svh"

module floor_controller_tb;

    localparam int WAIT_LIMIT = 60;

    logic                   clock;
    logic                   reset_n;
    floor_pkg::button_set_t call_buttons;
    floor_pkg::button_set_t panel_buttons;
    logic                   door_open_button;
    logic                   door_close_button;
    logic                   emergency;
    logic                   power;
    car_pkg::car_status_t   car_status;
    floor_pkg::button_set_t call_lights;
    floor_pkg::button_set_t panel_lights;
    car_pkg::car_command_t  car_command;
    car_pkg::door_permit_t  door_permit;
    integer                 seed;

    floor_controller dut_i (
        .clock             (clock),
        .reset_n           (reset_n),
        .call_buttons      (call_buttons),
        .panel_buttons     (panel_buttons),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .emergency         (emergency),
        .power             (power),
        .car_status        (car_status),
        .call_lights       (call_lights),
        .panel_lights      (panel_lights),
        .car_command       (car_command),
        .door_permit       (door_permit)
    );

    // 4 ns clock
    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Stopping at the first error");
    endtask

    `include "floor_controller_tasks.svh"

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        seed              = 32'hbfd60632;
        reset_n           = 1'b0;
        call_buttons      = '0;
        panel_buttons     = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency         = 1'b0;
        power             = 1'b1;
        // Car parked at floor 1
        car_status        = '0;

        repeat (5) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        test_reset_state();
        test_single_trip();
        test_arrival_order();
        test_blocked_presses();
        test_power_loss();
        test_door_permits();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/floor_controller.sv ====
// Floor request controller top joining request capture, request queue and car dispatch
`timescale 1ns/1ps
`default_nettype none

module floor_controller (
    input  logic                   clock,
    input  logic                   reset_n,
    input  floor_pkg::button_set_t call_buttons,
    input  floor_pkg::button_set_t panel_buttons,
    input  logic                   door_open_button,
    input  logic                   door_close_button,
    input  logic                   emergency,
    input  logic                   power,
    input  car_pkg::car_status_t   car_status,
    output floor_pkg::button_set_t call_lights,
    output floor_pkg::button_set_t panel_lights,
    output car_pkg::car_command_t  car_command,
    output car_pkg::door_permit_t  door_permit
);

    floor_pkg::floor_request_t new_request;
    floor_pkg::floor_request_t served;
    floor_pkg::floor_t         head;
    logic                      not_empty;

    request_capture capture_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .power         (power),
        .emergency     (emergency),
        .call_buttons  (call_buttons),
        .panel_buttons (panel_buttons),
        .current_floor (car_status.current_floor),
        .served        (served),
        .call_lights   (call_lights),
        .panel_lights  (panel_lights),
        .new_request   (new_request)
    );

    // Served strobe pops the head in the same edge as the lamp clear
    request_queue queue_i (
        .clock     (clock),
        .reset_n   (reset_n),
        .power     (power),
        .push      (new_request),
        .pop       (served.valid),
        .head      (head),
        .not_empty (not_empty)
    );

    car_dispatch dispatch_i (
        .clock             (clock),
        .reset_n           (reset_n),
        .power             (power),
        .emergency         (emergency),
        .car_status        (car_status),
        .head              (head),
        .not_empty         (not_empty),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .car_command       (car_command),
        .served            (served),
        .door_permit       (door_permit)
    );

endmodule

`default_nettype wire

// ==== verilog/car_dispatch.sv ====
// Car dispatcher that drives the car toward the queue head and grants door requests
`timescale 1ns/1ps
`default_nettype none

module car_dispatch (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      power,
    input  logic                      emergency,
    input  car_pkg::car_status_t      car_status,
    input  floor_pkg::floor_t         head,
    input  logic                      not_empty,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    output car_pkg::car_command_t     car_command,
    output floor_pkg::floor_request_t served,
    output car_pkg::door_permit_t     door_permit
);

    logic stopped;
    logic serve_now;
    logic move_now;

    always_comb begin
        stopped   = !car_status.moving;
        // Held off for one cycle so that a single pop reaches the queue
        serve_now = power && stopped && not_empty && !served.valid
                    && (head == car_status.current_floor);
        move_now  = power && !emergency && stopped && not_empty
                    && (head != car_status.current_floor);
    end

    ////////////////////
    // Car command
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            car_command <= '0;
        end else begin
            car_command.activate <= move_now;
            // Target and direction keep their last value while idle
            if (move_now) begin
                car_command.target_floor <= head;
                car_command.direction_up <= (head > car_status.current_floor);
            end
        end
    end

    // Arrival at the head floor
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            served <= '0;
        end else begin
            served.valid <= serve_now;
            if (serve_now) begin
                served.floor <= head;
            end
        end
    end

    ////////////////////
    // Door permits
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_permit <= '0;
        end else begin
            door_permit.open_allowed  <= power && stopped && door_open_button;
            door_permit.close_allowed <= power && stopped && door_close_button;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/request_queue.sv ====
// Request queue holding floor numbers in arrival order with the oldest one at its head
`timescale 1ns/1ps
`default_nettype none

`include "elevator_consts.svh"

module request_queue (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      power,
    input  floor_pkg::floor_request_t push,
    input  logic                      pop,
    output floor_pkg::floor_t         head,
    output logic                      not_empty
);

    localparam int PTR_WIDTH = $clog2(`QUEUE_DEPTH);

    floor_pkg::floor_t      entries [`QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [PTR_WIDTH:0]     count;
    logic                   do_push;
    logic                   do_pop;

    // Depth covers all lamps, so a push always finds room
    assign do_push = push.valid && power;
    assign do_pop  = pop && not_empty;

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[wr_ptr] <= push.floor;
        end
    end

    ////////////////////
    // Pointers and count
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (!power) begin
            // Power loss forgets every pending request
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Pointers wrap on their own at the power-of-two depth
    assign head      = entries[rd_ptr];
    assign not_empty = (count != '0);

endmodule

`default_nettype wire

// ==== verilog/request_capture.sv ====
// Request capture that latches button presses into lamps and clears lamps of served floors
`timescale 1ns/1ps
`default_nettype none

`include "elevator_consts.svh"

module request_capture (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      power,
    input  logic                      emergency,
    input  floor_pkg::button_set_t    call_buttons,
    input  floor_pkg::button_set_t    panel_buttons,
    input  floor_pkg::floor_t         current_floor,
    input  floor_pkg::floor_request_t served,
    output floor_pkg::button_set_t    call_lights,
    output floor_pkg::button_set_t    panel_lights,
    output floor_pkg::floor_request_t new_request
);

    floor_pkg::button_set_t    here_mask;
    floor_pkg::button_set_t    panel_ok;
    floor_pkg::button_set_t    call_ok;
    floor_pkg::floor_request_t panel_pick;
    floor_pkg::floor_request_t call_pick;
    floor_pkg::floor_request_t choice;

    // Lowest pressed floor wins
    function automatic floor_pkg::floor_request_t lowest_press(
        input floor_pkg::button_set_t presses
    );
        floor_pkg::floor_request_t pick;
        pick = '0;
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (presses[i]) begin
                pick.valid = 1'b1;
                pick.floor = floor_pkg::floor_t'(i);
            end
        end
        return pick;
    endfunction

    ////////////////////
    // Press selection
    ////////////////////

    always_comb begin
        // No request for the floor the car is standing at
        here_mask  = floor_pkg::button_set_t'(1) << current_floor;
        panel_ok   = panel_buttons & ~panel_lights & ~here_mask;
        call_ok    = call_buttons & ~call_lights & ~here_mask;
        panel_pick = lowest_press(panel_ok);
        call_pick  = lowest_press(call_ok);

        // Panel presses go first, a losing press retries while held
        if (panel_pick.valid) begin
            choice = panel_pick;
        end else begin
            choice = call_pick;
        end
        choice.valid = choice.valid && power && !emergency;
    end

    ////////////////////
    // Lamp registers
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
            new_request  <= '0;
        end else if (!power) begin
            call_lights  <= '0;
            panel_lights <= '0;
            new_request  <= '0;
        end else begin
            new_request <= choice;
            if (choice.valid) begin
                if (panel_pick.valid) begin
                    panel_lights[choice.floor] <= 1'b1;
                end else begin
                    call_lights[choice.floor] <= 1'b1;
                end
            end
            // Both lamps of a served floor go dark
            if (served.valid) begin
                call_lights[served.floor]  <= 1'b0;
                panel_lights[served.floor] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/car_pkg.sv ====
// Car package with status, command and door permission types of the motion controller link
`default_nettype none

package car_pkg;

    // Reported by the motion controller each cycle
    typedef struct packed {
        floor_pkg::floor_t current_floor;
        logic              moving;
    } car_status_t;

    // Sent to the motion controller
    typedef struct packed {
        floor_pkg::floor_t target_floor;
        // High when the target lies above the current floor
        logic              direction_up;
        logic              activate;
    } car_command_t;

    ////////////////////
    // Door control
    ////////////////////

    // Grants for the door operator, only while the car stands powered
    typedef struct packed {
        logic open_allowed;
        logic close_allowed;
    } door_permit_t;

endpackage

`default_nettype wire

// ==== verilog/floor_pkg.sv ====
// Floor package with floor number, button set and floor request types
`default_nettype none

`include "elevator_consts.svh"

package floor_pkg;

    ////////////////////
    // Floor numbering
    ////////////////////

    // Floor 1 is number 0, floor 11 is number 10
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, bit 0 is floor 1
    typedef logic [`FLOOR_COUNT-1:0] button_set_t;

    ////////////////////
    // Request strobe
    ////////////////////

    // Single-cycle notice of a floor, used for new requests and for served floors
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_request_t;

endpackage

`default_nettype wire

// ==== verilog/elevator_consts.svh ====
// Elevator constants for floor count, floor number width and request queue depth
`ifndef ELEVATOR_CONSTS_SVH
`define ELEVATOR_CONSTS_SVH

////////////////////
// Building size
////////////////////

// Floors 1 through 11
`define FLOOR_COUNT 11

// Floor number width, enough for floor numbers 0 to 10
`define FLOOR_WIDTH 4

////////////////////
// Request storage
////////////////////

// Room for every call lamp and every panel lamp at once
`define QUEUE_DEPTH 32

`endif
